/* hdl/spi_cfg_pkg.sv */
package spi_cfg_pkg;

  // frame widths.
  localparam int unsigned CMD_WIDTH   = 12;
  localparam int unsigned READ_WIDTH  = 8;
  localparam int unsigned ADDR_BITS   = 3;
  localparam int unsigned RD_HDR_BITS = 4;  // flag plus address.

  // width of the divider, turnaround and config data.
  localparam int unsigned CFG_WIDTH = 8;

  // reset values of the config registers.
  localparam logic [CFG_WIDTH-1:0] DIV_RESET  = 8'd3;
  localparam logic [CFG_WIDTH-1:0] TURN_RESET = 8'd8;

  // config register map.
  localparam logic CFG_ADDR_DIV  = 1'b0;
  localparam logic CFG_ADDR_TURN = 1'b1;

endpackage

/* hdl/spi_cmd_pkg.sv */
package spi_cmd_pkg;

  // bit position of the write flag, also the first bit on mosi.
  localparam int unsigned CMD_WR_BIT = 11;

  // write frame, all 12 bits go out.
  typedef struct packed {
    logic                                 wr;
    logic [spi_cfg_pkg::ADDR_BITS-1:0]    addr;
    logic [spi_cfg_pkg::READ_WIDTH-1:0]   data;
  } spi_wr_frame_t;

  // read frame, only the header is sent.
  typedef struct packed {
    logic                                 wr;
    logic [spi_cfg_pkg::ADDR_BITS-1:0]    addr;
    logic [spi_cfg_pkg::READ_WIDTH-1:0]   pad;
  } spi_rd_frame_t;

  // one command word, two decodes picked by wr.
  typedef union packed {
    spi_wr_frame_t wr_view;
    spi_rd_frame_t rd_view;
  } spi_cmd_u;

endpackage

/* hdl/spi_cfg_regs.sv */
module spi_cfg_regs (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cfg_we,
  input  logic       cfg_addr,
  input  logic [7:0] cfg_wdata,
  output logic [7:0] cfg_rdata,
  output logic [7:0] div,
  output logic [7:0] turn
);
  import spi_cfg_pkg::*;

  logic [CFG_WIDTH-1:0] div_q;
  logic [CFG_WIDTH-1:0] turn_q;
  logic                 wr_div;
  logic                 wr_turn;

  // address decode.
  assign wr_div  = cfg_we && (cfg_addr == CFG_ADDR_DIV);
  assign wr_turn = cfg_we && (cfg_addr == CFG_ADDR_TURN);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_q  <= DIV_RESET;
      turn_q <= TURN_RESET;
    end
    else
    begin
      if (wr_div)
      begin
        div_q <= cfg_wdata;
      end
      if (wr_turn)
      begin
        turn_q <= cfg_wdata;
      end
    end
  end

  // readback, no wait state.
  always_comb
  begin
    case (cfg_addr)
      CFG_ADDR_TURN:
      begin
        cfg_rdata = turn_q;
      end
      default:
      begin
        cfg_rdata = div_q;
      end
    endcase
  end

  assign div  = div_q;   // half period minus one.
  assign turn = turn_q;  // turnaround in clocks.

endmodule

/* hdl/spi_sclk_gen.sv */
module spi_sclk_gen (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sclk_en,
  input  logic [7:0] div,
  output logic       sclk,
  output logic       sclk_rise,
  output logic       sclk_fall
);
  import spi_cfg_pkg::*;

  logic [CFG_WIDTH-1:0] cnt_q;
  logic                 sclk_q;
  logic                 toggle;

  // half period is div+1 clocks.
  assign toggle = sclk_en && (cnt_q >= div);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q  <= '0;
      sclk_q <= 1'b0;
    end
    else if (!sclk_en)
    begin
      // idle, park low.
      cnt_q  <= '0;
      sclk_q <= 1'b0;
    end
    else if (toggle)
    begin
      cnt_q  <= '0;
      sclk_q <= ~sclk_q;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign sclk = sclk_q;

  // edge flags are high in the cycle that ends with the edge,
  // so the sequencer acts on the same clock that moves sclk.
  assign sclk_rise = toggle && !sclk_q;
  assign sclk_fall = toggle && sclk_q;

endmodule

/* hdl/spi_frame_seq.sv */
module spi_frame_seq (
  input  logic                                clk,
  input  logic                                rst_n,
  input  spi_cmd_pkg::spi_cmd_u               cmd_in,
  input  logic                                cmd_vld,
  output logic                                cmd_rdy,
  input  logic [7:0]                          turn,
  input  logic                                sclk_rise,
  input  logic                                sclk_fall,
  output logic                                sclk_en,
  output logic                                cs,
  output logic                                mosi,
  input  logic                                miso,
  output logic                                read_vld,
  output logic [spi_cfg_pkg::READ_WIDTH-1:0]  read_data
);
  import spi_cfg_pkg::*;
  import spi_cmd_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_SHIFT,
    ST_RD_HDR,
    ST_TURN,
    ST_RD_DATA,
    ST_DONE
  } state_t;

  state_t                state_q;
  state_t                state_d;
  logic [CMD_WIDTH-1:0]  shift_q;
  logic [3:0]            bit_cnt_q;
  logic [CFG_WIDTH-1:0]  turn_cnt_q;
  logic [CFG_WIDTH:0]    turn_next;
  logic [READ_WIDTH-1:0] cap_q;
  logic                  ready;
  logic                  accept;
  logic                  wr_last;
  logic                  hdr_last;
  logic                  data_last;
  logic                  turn_done;

  // done also takes a command, so back to back frames need no idle cycle.
  assign ready  = (state_q == ST_IDLE) || (state_q == ST_DONE);
  assign accept = ready && cmd_vld;

  assign wr_last   = (bit_cnt_q == 4'(CMD_WIDTH - 1));
  assign hdr_last  = (bit_cnt_q == 4'(RD_HDR_BITS - 1));
  assign data_last = (bit_cnt_q == 4'(READ_WIDTH - 1));

  // turnaround ends after turn clocks counted from the last header fall.
  assign turn_next = {1'b0, turn_cnt_q} + 1'b1;
  assign turn_done = (turn_next >= {1'b0, turn});

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE, ST_DONE:
      begin
        if (cmd_vld)
        begin
          state_d = cmd_in.wr_view.wr ? ST_WR_SHIFT : ST_RD_HDR;
        end
        else
        begin
          state_d = ST_IDLE;
        end
      end
      ST_WR_SHIFT:
      begin
        if (sclk_fall && wr_last)
        begin
          state_d = ST_IDLE;
        end
      end
      ST_RD_HDR:
      begin
        if (sclk_fall && hdr_last)
        begin
          state_d = ST_TURN;
        end
      end
      ST_TURN:
      begin
        if (turn_done)
        begin
          state_d = ST_RD_DATA;
        end
      end
      ST_RD_DATA:
      begin
        if (sclk_fall && data_last)
        begin
          state_d = ST_DONE;
        end
      end
      default:
      begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q    <= ST_IDLE;
      shift_q    <= '0;
      bit_cnt_q  <= '0;
      turn_cnt_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (accept)
      begin
        bit_cnt_q <= '0;
        if (cmd_in.wr_view.wr)
        begin
          shift_q <= {cmd_in.wr_view.wr, cmd_in.wr_view.addr, cmd_in.wr_view.data};
        end
        else
        begin
          // pad zeroed so mosi rests low after the header.
          shift_q <= {cmd_in.rd_view.wr, cmd_in.rd_view.addr, {READ_WIDTH{1'b0}}};
        end
      end
      else if (sclk_fall)
      begin
        shift_q <= {shift_q[CMD_WIDTH-2:0], 1'b0};  // next bit on mosi.
        if ((state_q == ST_RD_HDR) && hdr_last)
        begin
          bit_cnt_q  <= '0;
          turn_cnt_q <= '0;
        end
        else
        begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end
      else if (state_q == ST_TURN)
      begin
        turn_cnt_q <= turn_next[CFG_WIDTH-1:0];
      end
    end
  end

  // miso capture, msb first.
  always_ff @(posedge clk)
  begin
    if ((state_q == ST_RD_DATA) && sclk_rise)
    begin
      cap_q <= {cap_q[READ_WIDTH-2:0], miso};
    end
  end

  assign cmd_rdy   = ready;
  // low for the whole frame, turnaround included.
  assign cs        = !(sclk_en || (state_q == ST_TURN));
  assign sclk_en   = (state_q == ST_WR_SHIFT) || (state_q == ST_RD_HDR) ||
                     (state_q == ST_RD_DATA);
  assign mosi      = shift_q[CMD_WR_BIT];
  assign read_vld  = (state_q == ST_DONE);
  assign read_data = cap_q;

endmodule

/* hdl/spi_master_top.sv */
module spi_master_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  spi_cmd_pkg::spi_cmd_u               cmd_in,
  input  logic                                cmd_vld,
  output logic                                cmd_rdy,
  input  logic                                cfg_we,
  input  logic                                cfg_addr,
  input  logic [7:0]                          cfg_wdata,
  output logic [7:0]                          cfg_rdata,
  output logic                                sclk,
  output logic                                cs,
  output logic                                mosi,
  input  logic                                miso,
  output logic                                read_vld,
  output logic [spi_cfg_pkg::READ_WIDTH-1:0]  read_data
);

  logic [7:0] div;
  logic [7:0] turn;
  logic       sclk_en;
  logic       sclk_rise;
  logic       sclk_fall;

  spi_cfg_regs i_cfg_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .div       (div),
    .turn      (turn)
  );

  // serial clock, runs only while the sequencer shifts.
  spi_sclk_gen i_sclk_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk_en   (sclk_en),
    .div       (div),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall)
  );

  spi_frame_seq i_frame_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .turn      (turn),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .sclk_en   (sclk_en),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

/* dv/spi_dev_model.sv */
module spi_dev_model (
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso
);

  logic [7:0]  regs [0:7];
  logic [11:0] rx;
  logic [7:0]  tx;
  logic        rd;
  int unsigned nbits;

  initial
  begin
    for (int i = 0; i < 8; i++)
    begin
      regs[i] = 8'(i) ^ 8'ha5;  // power-up contents.
    end
    rx    = '0;
    tx    = '0;
    rd    = 1'b0;
    nbits = 0;
    miso  = 1'b0;
  end

  // mode 0, mosi sampled on the rising edge.
  always @(posedge sclk or posedge cs)
  begin
    if (cs)
    begin
      nbits = 0;
      rd    = 1'b0;
    end
    else
    begin
      if (nbits == 0)
      begin
        rd = !mosi;
      end
      rx    = {rx[10:0], mosi};
      nbits = nbits + 1;
      if ((nbits == 12) && !rd)
      begin
        regs[rx[10:8]] = rx[7:0];
      end
    end
  end

  // header ends on the 4th fall, msb goes out right there.
  always @(negedge sclk)
  begin
    if (!cs && rd && (nbits == 4))
    begin
      miso = regs[rx[2:0]][7];
      tx   = {regs[rx[2:0]][6:0], 1'b0};
    end
    else if (!cs && rd && (nbits > 4))
    begin
      miso = tx[7];
      tx   = {tx[6:0], 1'b0};
    end
  end

endmodule

/* dv/spi_master_sva.sv */
module spi_master_sva (
  input logic clk,
  input logic rst_n,
  input logic sclk,
  input logic cs,
  input logic mosi,
  input logic cmd_rdy,
  input logic read_vld
);

  idle_sclk_low: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk)
    else $error("sclk high while cs is high");

  vld_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) read_vld |=> !read_vld)
    else $error("read_vld held longer than one cycle");

  // mosi only moves on falling edges.
  mosi_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (sclk && $past(sclk)) |-> $stable(mosi))
    else $error("mosi changed while sclk high");

  busy_in_frame: assert property (@(posedge clk) disable iff (!rst_n) !cs |-> !cmd_rdy)
    else $error("cmd_rdy high inside a frame");

endmodule

bind spi_master_top spi_master_sva i_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .sclk     (sclk),
  .cs       (cs),
  .mosi     (mosi),
  .cmd_rdy  (cmd_rdy),
  .read_vld (read_vld)
);

/* dv/spi_master_tb.sv */
module spi_master_tb;

  typedef struct packed {
    logic       wr;
    logic [2:0] addr;
    logic [7:0] div;
    logic [7:0] turn;
    logic       poke;  // stray cmd_vld while busy.
    int         exp_half;
    int         exp_gap;
  } row_t;

  localparam int NUM_ROWS    = 25;
  localparam int RDY_LIMIT   = 1000;
  localparam int FRAME_LIMIT = 20000;

  // wr, addr, div, turn, poke, half period, turnaround gap.
  localparam row_t ROWS [NUM_ROWS] = '{
    '{1'b0, 3'd3, 8'd3, 8'd8, 1'b0, 4, 12},  // never written.
    '{1'b1, 3'd0, 8'd3, 8'd8, 1'b0, 4, 0}, '{1'b0, 3'd0, 8'd3, 8'd8, 1'b0, 4, 12},
    '{1'b1, 3'd1, 8'd3, 8'd8, 1'b0, 4, 0}, '{1'b0, 3'd1, 8'd3, 8'd8, 1'b0, 4, 12},
    '{1'b1, 3'd2, 8'd3, 8'd8, 1'b0, 4, 0}, '{1'b0, 3'd2, 8'd3, 8'd8, 1'b0, 4, 12},
    '{1'b1, 3'd3, 8'd3, 8'd8, 1'b0, 4, 0}, '{1'b0, 3'd3, 8'd3, 8'd8, 1'b0, 4, 12},
    '{1'b1, 3'd4, 8'd3, 8'd8, 1'b0, 4, 0}, '{1'b0, 3'd4, 8'd3, 8'd8, 1'b0, 4, 12},
    '{1'b1, 3'd5, 8'd3, 8'd8, 1'b0, 4, 0}, '{1'b0, 3'd5, 8'd3, 8'd8, 1'b0, 4, 12},
    '{1'b1, 3'd6, 8'd3, 8'd8, 1'b0, 4, 0}, '{1'b0, 3'd6, 8'd3, 8'd8, 1'b0, 4, 12},
    '{1'b1, 3'd7, 8'd3, 8'd8, 1'b0, 4, 0}, '{1'b0, 3'd7, 8'd3, 8'd8, 1'b0, 4, 12},
    '{1'b1, 3'd2, 8'd1, 8'd8, 1'b0, 2, 0}, '{1'b0, 3'd2, 8'd1, 8'd8, 1'b0, 2, 10},
    '{1'b1, 3'd5, 8'd5, 8'd8, 1'b0, 6, 0}, '{1'b0, 3'd5, 8'd5, 8'd8, 1'b0, 6, 14},
    '{1'b0, 3'd6, 8'd5, 8'd20, 1'b0, 6, 26},
    '{1'b0, 3'd1, 8'd1, 8'd20, 1'b0, 2, 22},
    '{1'b0, 3'd4, 8'd1, 8'd20, 1'b1, 2, 22},
    '{1'b0, 3'd4, 8'd3, 8'd8, 1'b0, 4, 12}  // still the old value.
  };

  logic        clk;
  logic        rst_n;
  logic [11:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        cfg_we;
  logic        cfg_addr;
  logic [7:0]  cfg_wdata;
  logic [7:0]  cfg_rdata;
  logic        sclk;
  logic        cs;
  logic        mosi;
  logic        miso;
  logic        read_vld;
  logic [7:0]  read_data;

  int          errors;
  int          checks;
  bit          aborted;
  logic [31:0] rng;
  logic [7:0]  mirror [0:7];
  logic [7:0]  cur_div;
  logic [7:0]  cur_turn;

  spi_master_top i_spi_master_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_dev_model i_dev (.sclk(sclk), .cs(cs), .mosi(mosi), .miso(miso));

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic wait_ready(output bit ok);
    int n;
    n = 0;
    while (!cmd_rdy && n < RDY_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    ok = cmd_rdy;
    if (!ok)
    begin
      $display("timeout: cmd_rdy never came back high");
      errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic write_cfg(input logic addr, input logic [7:0] data);
    bit ok;
    wait_ready(ok);
    if (!ok)
    begin
      return;
    end
    @(posedge clk);
    #1;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
    @(negedge clk);
    check(32'(cfg_rdata), 32'(data), "config readback");
  endtask

  task automatic run_frame(input logic [11:0] word, input logic rd, input logic [7:0] exp_data,
                           input logic poke, input int exp_half, input int exp_gap);
    bit   ok;
    bit   done;
    logic last_sclk;
    int   cyc;
    int   last_cyc;
    int   ntrans;
    wait_ready(ok);
    if (!ok)
    begin
      return;
    end
    @(posedge clk);
    #1;
    cmd_in  = word;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld   = 1'b0;
    done      = 1'b0;
    last_sclk = 1'b0;
    cyc       = 0;
    last_cyc  = 1;  // first cycle of the frame.
    ntrans    = 0;
    while (!done && cyc < FRAME_LIMIT)
    begin
      @(negedge clk);
      cyc++;
      if (sclk !== last_sclk)
      begin
        ntrans++;
        if (rd && ntrans == 9)
        begin
          check(cyc - last_cyc, exp_gap, "turnaround gap");
        end
        else
        begin
          check(cyc - last_cyc, exp_half, "sclk half period");
        end
        last_sclk = sclk;
        last_cyc  = cyc;
      end
      if (cs)
      begin
        done = 1'b1;
      end
      else if (poke && (cyc == 2 || cyc == 3))
      begin
        check(32'(cmd_rdy), 32'd0, "cmd_rdy during frame");
        @(posedge clk);
        #1;
        cmd_in  = {1'b1, word[10:8], ~mirror[word[10:8]]};  // must be dropped.
        cmd_vld = (cyc == 2);
      end
    end
    if (!done)
    begin
      $display("timeout: frame did not end, cs stayed low");
      errors++;
      aborted = 1'b1;
      return;
    end
    check(ntrans, 24, "sclk edges per frame");
    check(32'(cmd_rdy), 32'd1, "cmd_rdy at end of frame");
    check(32'(read_vld), 32'(rd), "read_vld at end of frame");
    if (rd)
    begin
      check(32'(read_data), 32'(exp_data), "read data");
    end
  endtask

  task automatic apply_row(input row_t r);
    logic [7:0] data;
    if (r.div != cur_div)
    begin
      write_cfg(1'b0, r.div);
      cur_div = r.div;
    end
    if (r.turn != cur_turn)
    begin
      write_cfg(1'b1, r.turn);
      cur_turn = r.turn;
    end
    if (aborted)
    begin
      return;
    end
    if (r.wr)
    begin
      rng  = xorshift(rng);
      data = rng[7:0];
      mirror[r.addr] = data;
    end
    else
    begin
      data = mirror[r.addr];
    end
    run_frame({r.wr, r.addr, r.wr ? data : 8'h00}, !r.wr, data, r.poke, r.exp_half, r.exp_gap);
  endtask

  initial
  begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = 1'b0;
    cfg_wdata = '0;
    errors    = 0;
    checks    = 0;
    aborted   = 1'b0;
    rng       = 32'd77202;
    cur_div   = 8'd3;
    cur_turn  = 8'd8;
    for (int i = 0; i < 8; i++)
    begin
      mirror[i] = 8'(i) ^ 8'ha5;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check(32'(cmd_rdy), 32'd1, "cmd_rdy after reset");
    check(32'(cs), 32'd1, "cs after reset");
    check(32'(sclk), 32'd0, "sclk after reset");
    check(32'(mosi), 32'd0, "mosi after reset");
    check(32'(read_vld), 32'd0, "read_vld after reset");
    check(32'(cfg_rdata), 32'd3, "div reset value");
    @(posedge clk);
    #1;
    cfg_addr = 1'b1;
    @(negedge clk);
    check(32'(cfg_rdata), 32'd8, "turn reset value");
    for (int r = 0; r < NUM_ROWS && !aborted; r++)
    begin
      apply_row(ROWS[r]);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
hdl/spi_cfg_pkg.sv
hdl/spi_cmd_pkg.sv
hdl/spi_cfg_regs.sv
hdl/spi_sclk_gen.sv
hdl/spi_frame_seq.sv
hdl/spi_master_top.sv
dv/spi_dev_model.sv
dv/spi_master_sva.sv
dv/spi_master_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= spi_master_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
